// File: hw/calc_pkg.sv
package calc_pkg;

  // width of one register and of each alu operand
  localparam int DATA_W = 4;

  // register number width
  localparam int ADDR_W = 2;

  // one register per address value
  localparam int NUM_REGS = 1 << ADDR_W;

  // msb of a data word, read as the sign in two's complement
  localparam int SIGN_BIT = DATA_W - 1;

  // opcode field width
  localparam int OP_W = 3;

  // register contents, immediate and alu result
  typedef logic [DATA_W-1:0] data_t;

  // read and write register numbers
  typedef logic [ADDR_W-1:0] reg_addr_t;

  // alu opcodes
  // all eight codes are decoded
  // 011 repeats and so the table has no hole
  typedef enum logic [OP_W-1:0] {
    // bitwise and
    OP_AND     = 3'b000,
    // bitwise or
    OP_OR      = 3'b001,
    // add, wraps modulo 16
    OP_ADD     = 3'b010,
    // second encoding of and
    OP_AND_ALT = 3'b011,
    // a and not immediate
    OP_AND_NOT = 3'b100,
    // a or not immediate
    OP_OR_NOT  = 3'b101,
    // subtract, wraps modulo 16
    OP_SUB     = 3'b110,
    // signed set-less-than, result is 0 or 1
    OP_SLT     = 3'b111
  } alu_op_e;

endpackage

// File: hw/regfile_if.sv
interface regfile_if
  import calc_pkg::*;
();

  // register number for the read port
  reg_addr_t rd_addr;

  // contents of the selected register
  data_t     rd_data;

  // register number that takes the result
  reg_addr_t wr_addr;

  // alu result, written every cycle
  data_t     wr_data;

  // register file side
  // owns the storage so it drives read data
  modport rf (
    input  rd_addr,
    input  wr_addr,
    input  wr_data,
    output rd_data
  );

  // alu side
  // reads operand a and returns the result
  modport core (
    input  rd_data,
    output wr_data
  );

endinterface

// File: hw/register_file.sv
module register_file
  import calc_pkg::*;
(
  input logic   clk,
  input logic   i_rst,
  regfile_if.rf rf
);

  // storage for all registers
  data_t regs [NUM_REGS];

  // write port
  // no enable so a result lands on every non-reset edge
  always_ff @(posedge clk) begin
    if (i_rst) begin
      // clear every register
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // selected register takes the alu result
      regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  // read port
  // plain mux on rd_addr, zero cycles
  // a write to the same register shows up after the edge
  assign rf.rd_data = regs[rf.rd_addr];

  // write address and data come from the top ports and the alu
  // an unknown here would corrupt a register silently
  wr_known_a : assert property (
    @(posedge clk) disable iff (i_rst)
    !$isunknown({rf.wr_addr, rf.wr_data})
  ) else begin
    $error("register_file: unknown write address or data");
  end

endmodule

// File: hw/add_sub.sv
module add_sub
  import calc_pkg::*;
(
  input  data_t i_a,
  input  data_t i_b,
  input  logic  i_sub,
  output data_t o_sum,
  output logic  o_lt
);

  // operand b, inverted when subtracting
  data_t b_mod;

  // a minus b, kept apart from o_sum for the compare
  data_t diff;

  // sign bits of both operands
  logic  a_neg;
  logic  b_neg;

  // ones' complement of b when i_sub is set
  assign b_mod = i_b ^ {DATA_W{i_sub}};

  // carry in of 1 completes the two's complement
  // carry out is dropped, so the sum wraps modulo 16
  assign o_sum = i_a + b_mod + data_t'(i_sub);

  // a minus b regardless of i_sub
  // lets the compare stay valid for any opcode
  assign diff = i_a + ~i_b + data_t'(1'b1);

  assign a_neg = i_a[SIGN_BIT];
  assign b_neg = i_b[SIGN_BIT];

  // signed less-than from the signs
  // a negative and b not gives 1
  // b negative and a not gives 0
  // same signs cannot overflow, so the difference sign is exact
  always_comb begin
    if (a_neg && !b_neg) begin
      o_lt = 1'b1;
    end else if (b_neg && !a_neg) begin
      o_lt = 1'b0;
    end else begin
      o_lt = diff[SIGN_BIT];
    end
  end

endmodule

// File: hw/alu.sv
module alu
  import calc_pkg::*;
(
  regfile_if.core core,
  input  data_t   i_immediate,
  input  alu_op_e i_control
);

  // operand a is the register being read
  data_t op_a;

  // bitwise results
  data_t and_res;
  data_t or_res;
  data_t and_not_res;
  data_t or_not_res;

  // sum or difference from the shared adder
  data_t arith_res;

  // adder runs as a subtractor
  logic  sub_sel;

  // signed a < immediate
  logic  lt;

  // selected result
  data_t result;

  assign op_a = core.rd_data;

  // logic unit
  assign and_res     = op_a & i_immediate;
  assign or_res      = op_a | i_immediate;
  assign and_not_res = op_a & ~i_immediate;
  assign or_not_res  = op_a | ~i_immediate;

  // sub for OP_SUB only matters to arith_res
  // OP_SLT takes lt, which never depends on sub_sel
  assign sub_sel = (i_control == OP_SUB) || (i_control == OP_SLT);

  // one adder serves add, sub and the compare
  add_sub i_add_sub (
    .i_a   (op_a),
    .i_b   (i_immediate),
    .i_sub (sub_sel),
    .o_sum (arith_res),
    .o_lt  (lt)
  );

  // result select by opcode
  always_comb begin
    case (i_control)
      OP_AND, OP_AND_ALT: result = and_res;
      OP_OR:              result = or_res;
      OP_ADD, OP_SUB:     result = arith_res;
      OP_AND_NOT:         result = and_not_res;
      OP_OR_NOT:          result = or_not_res;
      // zero-extended compare bit
      OP_SLT:             result = data_t'(lt);
      default:            result = '0;
    endcase

    // slt must equal the signed compare of the operands
    // checks the add_sub sign logic and the zero extension together
    if (i_control == OP_SLT && !$isunknown({op_a, i_immediate})) begin
      assert (result == data_t'($signed(op_a) < $signed(i_immediate)))
        else $error("alu: slt result %0h for a=%0h imm=%0h", result, op_a, i_immediate);
    end
  end

  // result goes back to the write port
  assign core.wr_data = result;

endmodule

// File: hw/calculator.sv
module calculator
  import calc_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,
  input  reg_addr_t i_rd_addr,
  input  reg_addr_t i_we_addr,
  input  alu_op_e   i_control,
  input  data_t     i_immediate,
  output data_t     o_rd_data
);

  // bus between the register file and the alu
  regfile_if rf_bus ();

  // addresses come straight from the ports
  assign rf_bus.rd_addr = i_rd_addr;
  assign rf_bus.wr_addr = i_we_addr;

  // read register is shown on the output
  // same word feeds the alu as operand a
  assign o_rd_data = rf_bus.rd_data;

  // storage with combinational read
  // written on every non-reset edge
  register_file i_register_file (
    .clk   (clk),
    .i_rst (i_rst),
    .rf    (rf_bus.rf)
  );

  // operand a from the read port
  // operand b is the immediate
  // result returns as the write data
  alu i_alu (
    .core        (rf_bus.core),
    .i_immediate (i_immediate),
    .i_control   (i_control)
  );

endmodule

// File: bench/calc_model.svh
`ifndef CALC_MODEL_SVH
`define CALC_MODEL_SVH

// register model, one word per dut register
// follows the dut edge by edge
data_t model_regs [NUM_REGS];

// model contents of one register
function automatic data_t model_read(input reg_addr_t addr);
  return model_regs[addr];
endfunction

// two's complement value of a data word
// msb weighs -8
function automatic int signed_value(input data_t v);
  int u;
  u = int'(v);
  if (v[DATA_W-1]) begin
    return u - (1 << DATA_W);
  end
  return u;
endfunction

// expected alu result for operand, immediate and opcode
// straight from the opcode table
function automatic data_t calc_result(input data_t a, input data_t b, input alu_op_e op);
  int    modulus;
  data_t res;
  modulus = 1 << DATA_W;
  case (op)
    OP_AND, OP_AND_ALT: res = a & b;
    OP_OR:              res = a | b;
    // add and sub wrap modulo 16
    OP_ADD:             res = data_t'((int'(a) + int'(b)) % modulus);
    OP_SUB:             res = data_t'((int'(a) - int'(b) + modulus) % modulus);
    OP_AND_NOT:         res = a & ~b;
    OP_OR_NOT:          res = a | ~b;
    // 1 in bit 0 only, upper bits zero
    OP_SLT:             res = (signed_value(a) < signed_value(b)) ? data_t'(1) : data_t'(0);
    default:            res = 'x;
  endcase
  return res;
endfunction

// short opcode name for error lines
function automatic string op_label(input alu_op_e op);
  case (op)
    OP_AND:     return "and";
    OP_OR:      return "or";
    OP_ADD:     return "add";
    OP_AND_ALT: return "and_alt";
    OP_AND_NOT: return "and_not";
    OP_OR_NOT:  return "or_not";
    OP_SUB:     return "sub";
    OP_SLT:     return "slt";
    default:    return "unknown";
  endcase
endfunction

// value the load test puts into register i
function automatic data_t load_value(input int i);
  return data_t'(4 * i + 3);
endfunction

`endif

// File: bench/tb_calculator.sv
module tb_calculator
  import calc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns clock
  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 3;
  localparam int RANDOM_CYCLES = 2000;
  // exhaustive loops take 8 ops x 256 pairs x 3 cycles or about 6150
  // random adds 2000 and reset plus load stay under 100
  // roughly 8200 cycles in all with spare left below the limit
  localparam int TIMEOUT_CYCLES = 10000;

  // dut inputs and output
  logic      clk;
  logic      rst;
  reg_addr_t rd_addr;
  reg_addr_t we_addr;
  alu_op_e   control;
  data_t     immediate;
  data_t     rd_data;

  `include "calc_model.svh"

  // bookkeeping
  string     cur_test;
  int        test_checks;
  int        test_errors;
  int        total_checks;
  int        total_errors;
  int        tests_run;
  int        tests_failed;
  int        cycle_count;
  int        seed;
  // register holding the last exhaustive result
  reg_addr_t last_wr;

  calculator i_calculator (
    .clk         (clk),
    .i_rst       (rst),
    .i_rd_addr   (rd_addr),
    .i_we_addr   (we_addr),
    .i_control   (control),
    .i_immediate (immediate),
    .o_rd_data   (rd_data)
  );

  always #HALF_PERIOD clk = ~clk;

  // model follows every edge with the pre-edge inputs
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] <= '0;
      end
    end else begin
      model_regs[we_addr] <= calc_result(model_regs[rd_addr], immediate, control);
    end
  end

  // compare read port with the model mid-cycle
  // inputs only move at posedge so the output is settled here
  always @(negedge clk) begin
    if (!rst) begin
      check($sformatf("%s rd=%0d", cur_test, rd_addr), model_read(rd_addr), rd_data);
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // compare one value and report a mismatch
  task automatic check(input string name, input data_t expected, input data_t actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      total_errors++;
      $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // one operation held from this posedge to the next
  task automatic drive_cycle(input reg_addr_t rd, input reg_addr_t we, input alu_op_e op,
                             input data_t imm);
    @(posedge clk);
    rd_addr   <= rd;
    we_addr   <= we;
    control   <= op;
    immediate <= imm;
  endtask

  // read a register and write its own value back
  task automatic read_reg(input reg_addr_t addr);
    drive_cycle(addr, addr, OP_OR, '0);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  // let the last cycle be compared before the report
  task automatic end_test();
    @(negedge clk);
    @(posedge clk);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %-7s %5d checks %4d errors", cur_test, test_checks, test_errors);
  endtask

  // every register reads 0 right after reset
  task automatic reset_readback();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_reg(reg_addr_t'(i));
      @(negedge clk);
      check($sformatf("reset reg%0d", i), '0, rd_data);
    end
    end_test();
  endtask

  // clear and load each register while the others hold
  task automatic load_and_hold();
    data_t exp;
    begin_test("load");
    for (int r = 0; r < NUM_REGS; r++) begin
      drive_cycle(reg_addr_t'(r), reg_addr_t'(r), OP_AND, '0);
      drive_cycle(reg_addr_t'(r), reg_addr_t'(r), OP_ADD, load_value(r));
      for (int i = 0; i < NUM_REGS; i++) begin
        // loaded up to r and still zero above
        if (i <= r) begin
          exp = load_value(i);
        end else begin
          exp = '0;
        end
        read_reg(reg_addr_t'(i));
        @(negedge clk);
        check($sformatf("load r%0d reg%0d", r, i), exp, rd_data);
      end
    end
    end_test();
  endtask

  // all 256 operand/immediate pairs for one opcode
  // 3 cycles each for clear, operand load and the op
  // previous result is read during the next clear
  task automatic sweep_pairs(input alu_op_e op);
    reg_addr_t r;
    reg_addr_t w;
    int        idx;
    bit        pending;
    data_t     pending_exp;
    string     pending_name;
    pending = 1'b0;
    for (int a = 0; a < (1 << DATA_W); a++) begin
      for (int b = 0; b < (1 << DATA_W); b++) begin
        idx = a * (1 << DATA_W) + b;
        // spread pairs over all source and target registers
        r = reg_addr_t'(idx);
        w = reg_addr_t'(idx >> ADDR_W);
        drive_cycle(last_wr, r, OP_AND, '0);
        @(negedge clk);
        if (pending) begin
          check(pending_name, pending_exp, rd_data);
        end
        drive_cycle(r, r, OP_ADD, data_t'(a));
        drive_cycle(r, w, op, data_t'(b));
        pending      = 1'b1;
        pending_exp  = calc_result(data_t'(a), data_t'(b), op);
        pending_name = $sformatf("%s %s a=%h b=%h", cur_test, op_label(op), a, b);
        last_wr      = w;
      end
    end
    // last pair
    read_reg(last_wr);
    @(negedge clk);
    check(pending_name, pending_exp, rd_data);
  endtask

  // random ops checked every cycle by the compare process
  task automatic random_sequence();
    logic [31:0] rnd;
    reg_addr_t   rd;
    reg_addr_t   we;
    begin_test("random");
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rnd = $random(seed);
      rd  = rnd[1:0];
      we  = rnd[3:2];
      // force read-after-write on the same register now and then
      if (n % 8 == 0) begin
        we = rd;
      end
      drive_cycle(rd, we, alu_op_e'(rnd[6:4]), rnd[10:7]);
    end
    end_test();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    rd_addr      = '0;
    we_addr      = '0;
    control      = OP_OR;
    immediate    = '0;
    seed         = 39;
    cycle_count  = 0;
    total_checks = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    last_wr      = '0;
    begin_test("reset");

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    reset_readback();
    load_and_hold();

    begin_test("logic");
    sweep_pairs(OP_AND);
    sweep_pairs(OP_AND_ALT);
    sweep_pairs(OP_OR);
    sweep_pairs(OP_AND_NOT);
    sweep_pairs(OP_OR_NOT);
    end_test();

    begin_test("arith");
    sweep_pairs(OP_ADD);
    sweep_pairs(OP_SUB);
    end_test();

    begin_test("slt");
    sweep_pairs(OP_SLT);
    end_test();

    random_sequence();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errors);
    if (total_errors == 0 && total_checks > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
hw/calc_pkg.sv
hw/regfile_if.sv
hw/register_file.sv
hw/add_sub.sv
hw/alu.sv
hw/calculator.sv
bench/tb_calculator.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_calculator \
  -f tb.f \
  -o tb_calculator_sim

out=$(./obj_dir/tb_calculator_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
else
  exit 1
fi
